// File: hw/hart_pkg.sv
package hart_pkg;

	// data and address width
	localparam int XLEN = 32;
	// integer register file depth
	localparam int REG_COUNT = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

	// decoded operations
	// OP_NONE marks a bubble in any stage
	typedef enum logic [3:0] {
		OP_NONE,
		OP_LUI,
		OP_ADDI,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_BNE,
		OP_JAL
	} op_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcode_t;

	// four-phase handshake on the instruction port
	typedef enum logic [1:0] {FETCH_REQ, FETCH_WAIT_ACK, FETCH_RELEASE, FETCH_DONE} fetch_state_t;

	// four-phase handshake on the data port
	typedef enum logic [1:0] {DATA_IDLE, DATA_WAIT_ACK, DATA_RELEASE, DATA_DONE} data_state_t;

	// ops that put a value into rd
	function automatic logic writes_rd(input op_t op);
		return op inside {OP_LUI, OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
			OP_LW, OP_JAL};
	endfunction

endpackage

// File: hw/pipeline_controller.sv
module pipeline_controller import hart_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input  logic  clock_bus_i,
	input  logic  reset_i,
	input  logic  inst_ack_i,
	input  word_t inst_data_i,
	input  logic  data_ack_i,
	input  word_t data_rdata_i,
	input  logic  load_use_i,
	input  logic  redirect_i,
	input  word_t redirect_pc_i,
	input  logic  mem_read_i,
	input  logic  mem_write_i,
	input  word_t mem_addr_i,
	input  word_t mem_wdata_i,
	output logic  inst_req_o,
	output word_t inst_addr_o,
	output logic  data_req_o,
	output logic  data_wren_o,
	output word_t data_addr_o,
	output word_t data_wdata_o,
	output word_t fetch_word_o,
	output word_t fetch_pc_o,
	output word_t load_data_o,
	output logic  front_advance_o,
	output logic  back_advance_o,
	output logic  flush_o
);

	fetch_state_t fetch_state;
	data_state_t data_state;
	word_t pc_q;
	word_t fetch_word_q;
	word_t load_data_q;
	word_t data_addr_q;
	word_t data_wdata_q;
	logic data_req_q;
	logic data_wren_q;
	logic data_done;
	logic advance;

	// ------------------------------
	// stage advance and flush

	// data side is ready when nothing is pending or the access of the
	// execute instruction has fully closed
	assign data_done = (data_state == DATA_DONE) ||
		(data_state == DATA_IDLE && !mem_read_i && !mem_write_i);
	assign advance = (fetch_state == FETCH_DONE) && data_done;
	assign back_advance_o = advance;
	// load-use holds fetch, decode and operand fetch for one step
	assign front_advance_o = advance && !load_use_i;
	// bubble into execute on load-use, bubbles into all three on redirect
	assign flush_o = redirect_i || load_use_i;

	// ------------------------------
	// instruction port
	assign inst_req_o = (fetch_state == FETCH_REQ) || (fetch_state == FETCH_WAIT_ACK);
	assign inst_addr_o = pc_q;
	// pc only moves on advance so it still names the held word
	assign fetch_pc_o = pc_q;
	assign fetch_word_o = fetch_word_q;

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			fetch_state <= FETCH_REQ;
			pc_q <= RESET_PC;
		end else begin
			case (fetch_state)
				FETCH_REQ, FETCH_WAIT_ACK: begin
					// req drops together with the data latch
					fetch_state <= inst_ack_i ? FETCH_RELEASE : FETCH_WAIT_ACK;
				end
				FETCH_RELEASE: begin
					if (!inst_ack_i)
						fetch_state <= FETCH_DONE;
				end
				FETCH_DONE: begin
					if (front_advance_o) begin
						fetch_state <= FETCH_REQ;
						// always predict fall-through
						pc_q <= redirect_i ? redirect_pc_i : pc_q + word_t'(4);
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (inst_req_o && inst_ack_i)
			fetch_word_q <= inst_data_i;
	end

	// ------------------------------
	// data port
	assign data_req_o = data_req_q;
	assign data_wren_o = data_wren_q;
	assign data_addr_o = data_addr_q;
	assign data_wdata_o = data_wdata_q;
	assign load_data_o = load_data_q;

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			data_state <= DATA_IDLE;
			data_req_q <= 1'b0;
			data_wren_q <= 1'b0;
		end else begin
			case (data_state)
				DATA_IDLE: begin
					// ack is known low here, the last access ended in DATA_DONE
					if (mem_read_i || mem_write_i) begin
						data_state <= DATA_WAIT_ACK;
						data_req_q <= 1'b1;
						data_wren_q <= mem_write_i;
					end
				end
				DATA_WAIT_ACK: begin
					if (data_ack_i) begin
						data_state <= DATA_RELEASE;
						data_req_q <= 1'b0;
						data_wren_q <= 1'b0;
					end
				end
				DATA_RELEASE: begin
					if (!data_ack_i)
						data_state <= DATA_DONE;
				end
				DATA_DONE: begin
					// next execute instruction may start its own access
					if (advance)
						data_state <= DATA_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock_bus_i) begin
		// address and write data freeze once req is up
		if (data_state == DATA_IDLE) begin
			data_addr_q <= mem_addr_i;
			data_wdata_q <= mem_wdata_i;
		end
		if (data_state == DATA_WAIT_ACK && data_ack_i)
			load_data_q <= data_rdata_i;
	end

	// ------------------------------
	// four-phase rule against the memory side
	inst_req_held: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		inst_req_o && !inst_ack_i |=> inst_req_o);
	inst_req_rise: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		$rose(inst_req_o) |-> $past(!inst_ack_i));
	data_req_held: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		data_req_o && !data_ack_i |=> data_req_o);
	data_req_rise: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		$rose(data_req_o) |-> $past(!data_ack_i));

endmodule

// File: hw/inst_decoder.sv
module inst_decoder import hart_pkg::*; (
	input  logic     clock_bus_i,
	input  logic     reset_i,
	input  logic     front_advance_i,
	input  logic     flush_i,
	input  word_t    fetch_word_i,
	input  word_t    fetch_pc_i,
	output op_t      op_o,
	output reg_idx_t rs1_o,
	output reg_idx_t rs2_o,
	output reg_idx_t rd_o,
	output word_t    imm_o,
	output word_t    pc_o
);

	logic valid_q;
	word_t word_q;
	word_t pc_q;
	logic [2:0] funct3;
	logic [6:0] funct7;
	op_t dec_op;

	// ------------------------------
	// decode stage register
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			valid_q <= 1'b0;
		end else if (front_advance_i) begin
			// wrong-path word is dropped on redirect
			valid_q <= !flush_i;
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (front_advance_i) begin
			word_q <= fetch_word_i;
			pc_q <= fetch_pc_i;
		end
	end

	// ------------------------------
	// field extraction
	assign funct3 = word_q[14:12];
	assign funct7 = word_q[31:25];
	assign rd_o = word_q[11:7];
	assign rs1_o = word_q[19:15];
	assign rs2_o = word_q[24:20];
	assign pc_o = pc_q;
	assign op_o = valid_q ? dec_op : OP_NONE;

	// op and immediate by major opcode
	// anything outside the subset falls to OP_NONE
	always_comb begin
		dec_op = OP_NONE;
		imm_o = '0;
		case (opcode_t'(word_q[6:0]))
			LUI: begin
				dec_op = OP_LUI;
				imm_o = {word_q[31:12], 12'b0};
			end
			OP_IMM: begin
				if (funct3 == 3'b000)
					dec_op = OP_ADDI;
				imm_o = {{20{word_q[31]}}, word_q[31:20]};
			end
			OP: begin
				case ({funct7, funct3})
					10'b0000000_000: dec_op = OP_ADD;
					10'b0100000_000: dec_op = OP_SUB;
					10'b0000000_111: dec_op = OP_AND;
					10'b0000000_110: dec_op = OP_OR;
					10'b0000000_100: dec_op = OP_XOR;
					10'b0000000_010: dec_op = OP_SLT;
					default: dec_op = OP_NONE;
				endcase
			end
			LOAD: begin
				// word loads only
				if (funct3 == 3'b010)
					dec_op = OP_LW;
				imm_o = {{20{word_q[31]}}, word_q[31:20]};
			end
			STORE: begin
				if (funct3 == 3'b010)
					dec_op = OP_SW;
				imm_o = {{20{word_q[31]}}, word_q[31:25], word_q[11:7]};
			end
			BRANCH: begin
				if (funct3 == 3'b000)
					dec_op = OP_BEQ;
				else if (funct3 == 3'b001)
					dec_op = OP_BNE;
				imm_o = {{19{word_q[31]}}, word_q[31], word_q[7], word_q[30:25],
					word_q[11:8], 1'b0};
			end
			JAL: begin
				dec_op = OP_JAL;
				imm_o = {{11{word_q[31]}}, word_q[31], word_q[19:12], word_q[20],
					word_q[30:21], 1'b0};
			end
			default: dec_op = OP_NONE;
		endcase
	end

endmodule

// File: hw/operand_fetch.sv
module operand_fetch import hart_pkg::*; #(
	parameter word_t STACK_BASE = '0
) (
	input  logic     clock_bus_i,
	input  logic     reset_i,
	input  logic     front_advance_i,
	input  logic     flush_i,
	input  op_t      op_i,
	input  reg_idx_t rs1_i,
	input  reg_idx_t rs2_i,
	input  reg_idx_t rd_i,
	input  word_t    imm_i,
	input  word_t    pc_i,
	input  op_t      ex_op_i,
	input  reg_idx_t ex_rd_i,
	input  word_t    ex_result_i,
	input  reg_idx_t mem_rd_i,
	input  logic     mem_valid_i,
	input  word_t    mem_result_i,
	input  logic     wb_en_i,
	input  reg_idx_t wb_rd_i,
	input  word_t    wb_value_i,
	output op_t      op_o,
	output reg_idx_t rd_o,
	output word_t    src1_o,
	output word_t    src2_o,
	output word_t    imm_o,
	output word_t    pc_o,
	output logic     load_use_o
);

	word_t regs [REG_COUNT];
	op_t op_q;
	reg_idx_t rs1_q;
	reg_idx_t rs2_q;
	logic ex_fwd;

	// ------------------------------
	// register file
	// writeback never targets x0, so x0 stays at its reset zero
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= (i == 2) ? STACK_BASE : '0;
		end else if (wb_en_i) begin
			regs[wb_rd_i] <= wb_value_i;
		end
	end

	// ------------------------------
	// operand stage register
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i)
			op_q <= OP_NONE;
		else if (front_advance_i)
			op_q <= flush_i ? OP_NONE : op_i;
	end

	always_ff @(posedge clock_bus_i) begin
		if (front_advance_i) begin
			rs1_q <= rs1_i;
			rs2_q <= rs2_i;
			rd_o <= rd_i;
			imm_o <= imm_i;
			pc_o <= pc_i;
		end
	end

	assign op_o = op_q;

	// a load in execute has no data yet, it is covered by the stall
	assign ex_fwd = writes_rd(ex_op_i) && ex_op_i != OP_LW && ex_rd_i != '0;

	// youngest producer wins, then memory, then the write port bypass
	function automatic word_t select_operand(input reg_idx_t idx);
		if (ex_fwd && ex_rd_i == idx)
			return ex_result_i;
		if (mem_valid_i && mem_rd_i == idx)
			return mem_result_i;
		if (wb_en_i && wb_rd_i == idx)
			return wb_value_i;
		return regs[idx];
	endfunction

	assign src1_o = select_operand(rs1_q);
	assign src2_o = select_operand(rs2_q);

	// conservative match on both fields, unused fields only cost a bubble
	assign load_use_o = ex_op_i == OP_LW && ex_rd_i != '0 && op_q != OP_NONE &&
		(ex_rd_i == rs1_q || ex_rd_i == rs2_q);

	x0_zero: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		regs[0] == '0);

endmodule

// File: hw/execute_unit.sv
module execute_unit import hart_pkg::*; (
	input  logic     clock_bus_i,
	input  logic     reset_i,
	input  logic     back_advance_i,
	input  logic     flush_i,
	input  op_t      op_i,
	input  reg_idx_t rd_i,
	input  word_t    src1_i,
	input  word_t    src2_i,
	input  word_t    imm_i,
	input  word_t    pc_i,
	output op_t      op_o,
	output reg_idx_t rd_o,
	output word_t    result_o,
	output logic     redirect_o,
	output word_t    redirect_pc_o,
	output logic     mem_read_o,
	output logic     mem_write_o,
	output word_t    mem_addr_o,
	output word_t    mem_wdata_o
);

	op_t op_q;
	word_t src1_q;
	word_t src2_q;
	word_t imm_q;
	word_t pc_q;
	logic src_equal;

	// ------------------------------
	// execute stage register
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i)
			op_q <= OP_NONE;
		else if (back_advance_i)
			op_q <= flush_i ? OP_NONE : op_i;
	end

	always_ff @(posedge clock_bus_i) begin
		if (back_advance_i) begin
			rd_o <= rd_i;
			src1_q <= src1_i;
			src2_q <= src2_i;
			imm_q <= imm_i;
			pc_q <= pc_i;
		end
	end

	assign op_o = op_q;

	// ------------------------------
	// alu
	always_comb begin
		case (op_q)
			OP_LUI: result_o = imm_q;
			OP_ADDI: result_o = src1_q + imm_q;
			OP_ADD: result_o = src1_q + src2_q;
			OP_SUB: result_o = src1_q - src2_q;
			OP_AND: result_o = src1_q & src2_q;
			OP_OR: result_o = src1_q | src2_q;
			OP_XOR: result_o = src1_q ^ src2_q;
			OP_SLT: result_o = word_t'($signed(src1_q) < $signed(src2_q));
			// link value
			OP_JAL: result_o = pc_q + word_t'(4);
			default: result_o = '0;
		endcase
	end

	// ------------------------------
	// branch and jump resolution
	assign src_equal = (src1_q == src2_q);
	assign redirect_o = (op_q == OP_BEQ && src_equal) || (op_q == OP_BNE && !src_equal) ||
		(op_q == OP_JAL);
	// pc relative for both branches and jal
	assign redirect_pc_o = pc_q + imm_q;

	// load/store request toward the controller
	assign mem_read_o = (op_q == OP_LW);
	assign mem_write_o = (op_q == OP_SW);
	assign mem_addr_o = src1_q + imm_q;
	assign mem_wdata_o = src2_q;

endmodule

// File: hw/memory_writeback.sv
module memory_writeback import hart_pkg::*; (
	input  logic     clock_bus_i,
	input  logic     reset_i,
	input  logic     back_advance_i,
	input  op_t      op_i,
	input  reg_idx_t rd_i,
	input  word_t    result_i,
	input  word_t    load_data_i,
	output reg_idx_t rd_o,
	output logic     valid_o,
	output word_t    result_o,
	output logic     wb_en_o,
	output reg_idx_t wb_rd_o,
	output word_t    wb_value_o
);

	op_t op_q;

	// ------------------------------
	// memory stage
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i)
			op_q <= OP_NONE;
		else if (back_advance_i)
			op_q <= op_i;
	end

	// load data is already latched when the load leaves execute
	always_ff @(posedge clock_bus_i) begin
		if (back_advance_i) begin
			rd_o <= rd_i;
			result_o <= (op_i == OP_LW) ? load_data_i : result_i;
		end
	end

	// also the forwarding qualifier for operand fetch
	assign valid_o = writes_rd(op_q) && rd_o != '0;

	// ------------------------------
	// writeback stage
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i)
			wb_en_o <= 1'b0;
		else if (back_advance_i)
			wb_en_o <= valid_o;
	end

	always_ff @(posedge clock_bus_i) begin
		if (back_advance_i) begin
			wb_rd_o <= rd_o;
			wb_value_o <= result_o;
		end
	end

endmodule

// File: hw/riscv_hart.sv
module riscv_hart import hart_pkg::*; #(
	parameter word_t RESET_PC = '0,
	parameter word_t STACK_BASE = 32'h0000_2000
) (
	input  logic  clock_bus_i,
	input  logic  reset_i,
	// instruction port
	output logic  inst_req_o,
	output word_t inst_addr_o,
	input  logic  inst_ack_i,
	input  word_t inst_data_i,
	// data port
	output logic  data_req_o,
	output logic  data_wren_o,
	output word_t data_addr_o,
	output word_t data_wdata_o,
	input  logic  data_ack_i,
	input  word_t data_rdata_i
);

	// controller
	logic front_advance;
	logic back_advance;
	logic flush;
	word_t fetch_word;
	word_t fetch_pc;
	word_t load_data;

	// decode
	op_t dec_op;
	reg_idx_t dec_rs1;
	reg_idx_t dec_rs2;
	reg_idx_t dec_rd;
	word_t dec_imm;
	word_t dec_pc;

	// operand fetch
	op_t of_op;
	reg_idx_t of_rd;
	word_t of_src1;
	word_t of_src2;
	word_t of_imm;
	word_t of_pc;
	logic load_use;

	// execute
	op_t ex_op;
	reg_idx_t ex_rd;
	word_t ex_result;
	logic redirect;
	word_t redirect_pc;
	logic mem_read;
	logic mem_write;
	word_t mem_addr;
	word_t mem_wdata;

	// memory and writeback
	reg_idx_t mem_rd;
	logic mem_valid;
	word_t mem_result;
	logic wb_en;
	reg_idx_t wb_rd;
	word_t wb_value;

	pipeline_controller #(.RESET_PC(RESET_PC)) u_pipeline_controller (
		.clock_bus_i(clock_bus_i), .reset_i(reset_i),
		.inst_ack_i(inst_ack_i), .inst_data_i(inst_data_i),
		.data_ack_i(data_ack_i), .data_rdata_i(data_rdata_i),
		.load_use_i(load_use), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
		.mem_read_i(mem_read), .mem_write_i(mem_write),
		.mem_addr_i(mem_addr), .mem_wdata_i(mem_wdata),
		.inst_req_o(inst_req_o), .inst_addr_o(inst_addr_o),
		.data_req_o(data_req_o), .data_wren_o(data_wren_o),
		.data_addr_o(data_addr_o), .data_wdata_o(data_wdata_o),
		.fetch_word_o(fetch_word), .fetch_pc_o(fetch_pc), .load_data_o(load_data),
		.front_advance_o(front_advance), .back_advance_o(back_advance), .flush_o(flush)
	);

	inst_decoder u_inst_decoder (
		.clock_bus_i(clock_bus_i), .reset_i(reset_i),
		.front_advance_i(front_advance), .flush_i(flush),
		.fetch_word_i(fetch_word), .fetch_pc_i(fetch_pc),
		.op_o(dec_op), .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd),
		.imm_o(dec_imm), .pc_o(dec_pc)
	);

	operand_fetch #(.STACK_BASE(STACK_BASE)) u_operand_fetch (
		.clock_bus_i(clock_bus_i), .reset_i(reset_i),
		.front_advance_i(front_advance), .flush_i(flush),
		.op_i(dec_op), .rs1_i(dec_rs1), .rs2_i(dec_rs2), .rd_i(dec_rd),
		.imm_i(dec_imm), .pc_i(dec_pc),
		.ex_op_i(ex_op), .ex_rd_i(ex_rd), .ex_result_i(ex_result),
		.mem_rd_i(mem_rd), .mem_valid_i(mem_valid), .mem_result_i(mem_result),
		.wb_en_i(wb_en), .wb_rd_i(wb_rd), .wb_value_i(wb_value),
		.op_o(of_op), .rd_o(of_rd), .src1_o(of_src1), .src2_o(of_src2),
		.imm_o(of_imm), .pc_o(of_pc), .load_use_o(load_use)
	);

	execute_unit u_execute_unit (
		.clock_bus_i(clock_bus_i), .reset_i(reset_i),
		.back_advance_i(back_advance), .flush_i(flush),
		.op_i(of_op), .rd_i(of_rd), .src1_i(of_src1), .src2_i(of_src2),
		.imm_i(of_imm), .pc_i(of_pc),
		.op_o(ex_op), .rd_o(ex_rd), .result_o(ex_result),
		.redirect_o(redirect), .redirect_pc_o(redirect_pc),
		.mem_read_o(mem_read), .mem_write_o(mem_write),
		.mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata)
	);

	memory_writeback u_memory_writeback (
		.clock_bus_i(clock_bus_i), .reset_i(reset_i), .back_advance_i(back_advance),
		.op_i(ex_op), .rd_i(ex_rd), .result_i(ex_result), .load_data_i(load_data),
		.rd_o(mem_rd), .valid_o(mem_valid), .result_o(mem_result),
		.wb_en_o(wb_en), .wb_rd_o(wb_rd), .wb_value_o(wb_value)
	);

endmodule

// File: test/tb_memory.sv
module tb_memory (
	input  logic        clock_bus_i,
	input  logic        reset_i,
	input  logic        inst_req_i,
	input  logic [31:0] inst_addr_i,
	output logic        inst_ack_o,
	output logic [31:0] inst_data_o,
	input  logic        data_req_i,
	input  logic        data_wren_i,
	input  logic [31:0] data_addr_i,
	input  logic [31:0] data_wdata_i,
	output logic        data_ack_o,
	output logic [31:0] data_rdata_o
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] imem [64];
	logic [31:0] dmem [1024];
	integer seed;
	int inst_delay;
	int data_delay;
	logic inst_busy;
	logic data_busy;

	initial begin
		seed = 18;
		inst_ack_o = 1'b0;
		inst_data_o = '0;
		data_ack_o = 1'b0;
		data_rdata_o = '0;
		inst_busy = 1'b0;
		data_busy = 1'b0;
		inst_delay = 0;
		data_delay = 0;
		// fill word carries its own byte address
		for (int i = 0; i < 1024; i++)
			dmem[i] = 32'hc0de_0000 | (i << 2);
		// nops past the program
		for (int i = 0; i < 64; i++)
			imem[i] = 32'h0000_0013;
		// alu chain
		imem[0] = 32'h00d0_0093;   // addi x1,x0,13
		imem[1] = 32'h0070_8193;   // addi x3,x1,7
		imem[2] = 32'h0011_8233;   // add x4,x3,x1
		imem[3] = 32'h4032_02b3;   // sub x5,x4,x3
		imem[4] = 32'h0051_f333;   // and x6,x3,x5
		imem[5] = 32'h0043_63b3;   // or x7,x6,x4
		imem[6] = 32'h0033_c433;   // xor x8,x7,x3
		imem[7] = 32'h0083_24b3;   // slt x9,x6,x8
		imem[8] = 32'h1234_5537;   // lui x10,0x12345
		imem[9] = 32'h0085_05b3;   // add x11,x10,x8
		imem[10] = 32'h00b1_2023;  // sw x11,0(x2)
		imem[11] = 32'h0091_2223;  // sw x9,4(x2)
		imem[12] = 32'h0051_2423;  // sw x5,8(x2)
		// load then dependent add
		imem[13] = 32'h0101_2603;  // lw x12,16(x2)
		imem[14] = 32'h0076_06b3;  // add x13,x12,x7
		imem[15] = 32'h00d1_2623;  // sw x13,12(x2)
		// control flow, x14 holds the poison word
		imem[16] = 32'h6660_0713;  // addi x14,x0,0x666
		imem[17] = 32'h0050_8663;  // beq x1,x5,+12
		imem[18] = 32'h00e1_2a23;  // sw x14,20(x2)
		imem[19] = 32'h00e1_2c23;  // sw x14,24(x2)
		imem[20] = 32'h0050_9463;  // bne x1,x5,+8
		imem[21] = 32'h0061_2823;  // sw x6,16(x2)
		imem[22] = 32'h00c0_07ef;  // jal x15,+12
		imem[23] = 32'h00e1_2e23;  // sw x14,28(x2)
		imem[24] = 32'h02e1_2023;  // sw x14,32(x2)
		imem[25] = 32'h02f1_2223;  // sw x15,36(x2)
		imem[26] = 32'h0221_2423;  // sw x2,40(x2)
		imem[27] = 32'h0000_006f;  // jal x0,0
	end

	// ------------------------------
	// instruction port, 0 to 3 cycles before ack
	always @(negedge clock_bus_i) begin
		if (!reset_i) begin
			inst_ack_o = 1'b0;
			inst_busy = 1'b0;
		end else if (!inst_ack_o && inst_req_i) begin
			if (!inst_busy) begin
				inst_busy = 1'b1;
				inst_delay = $unsigned($random(seed)) % 4;
			end
			if (inst_delay == 0) begin
				inst_data_o = imem[inst_addr_i[7:2]];
				inst_ack_o = 1'b1;
				inst_busy = 1'b0;
			end else begin
				inst_delay--;
			end
		end else if (inst_ack_o && !inst_req_i) begin
			inst_ack_o = 1'b0;
		end
	end

	// ------------------------------
	// data port
	always @(negedge clock_bus_i) begin
		if (!reset_i) begin
			data_ack_o = 1'b0;
			data_busy = 1'b0;
		end else if (!data_ack_o && data_req_i) begin
			if (!data_busy) begin
				data_busy = 1'b1;
				data_delay = $unsigned($random(seed)) % 4;
			end
			if (data_delay == 0) begin
				if (data_wren_i)
					dmem[data_addr_i[11:2]] = data_wdata_i;
				data_rdata_o = dmem[data_addr_i[11:2]];
				data_ack_o = 1'b1;
				data_busy = 1'b0;
			end else begin
				data_delay--;
			end
		end else if (data_ack_o && !data_req_i) begin
			data_ack_o = 1'b0;
		end
	end

endmodule

// File: test/tb_riscv_hart.sv
module tb_riscv_hart;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;
	localparam logic [31:0] STACK_BASE = 32'h0000_2000;
	localparam int STORE_COUNT = 7;
	localparam int RUN_LIMIT = 3000;
	localparam int ACK_LIMIT = 12;
	localparam int DRAIN_CYCLES = 40;
	localparam logic [31:0] POISON = 32'h0000_0666;

	// expected stores in program order
	localparam logic [31:0] EXP_ADDR [STORE_COUNT] = '{
		32'h0000_2000, 32'h0000_2004, 32'h0000_2008, 32'h0000_200c,
		32'h0000_2010, 32'h0000_2024, 32'h0000_2028
	};
	localparam logic [31:0] EXP_DATA [STORE_COUNT] = '{
		32'h1234_5031, 32'h0000_0001, 32'h0000_000d, 32'hc0de_0035,
		32'h0000_0004, 32'h0000_005c, 32'h0000_2000
	};

	logic clock_bus_i;
	logic reset_i;
	logic inst_req_o;
	logic [31:0] inst_addr_o;
	logic inst_ack_i;
	logic [31:0] inst_data_i;
	logic data_req_o;
	logic data_wren_o;
	logic [31:0] data_addr_o;
	logic [31:0] data_wdata_o;
	logic data_ack_i;
	logic [31:0] data_rdata_i;

	int store_idx;
	logic store_prev;
	int cycles;
	int drain;
	int inst_wait;
	int data_wait;

	always #50 clock_bus_i = ~clock_bus_i;

	riscv_hart #(.RESET_PC(RESET_PC), .STACK_BASE(STACK_BASE)) u_riscv_hart (
		.clock_bus_i(clock_bus_i), .reset_i(reset_i),
		.inst_req_o(inst_req_o), .inst_addr_o(inst_addr_o),
		.inst_ack_i(inst_ack_i), .inst_data_i(inst_data_i),
		.data_req_o(data_req_o), .data_wren_o(data_wren_o),
		.data_addr_o(data_addr_o), .data_wdata_o(data_wdata_o),
		.data_ack_i(data_ack_i), .data_rdata_i(data_rdata_i)
	);

	tb_memory u_tb_memory (
		.clock_bus_i(clock_bus_i), .reset_i(reset_i),
		.inst_req_i(inst_req_o), .inst_addr_i(inst_addr_o),
		.inst_ack_o(inst_ack_i), .inst_data_o(inst_data_i),
		.data_req_i(data_req_o), .data_wren_i(data_wren_o),
		.data_addr_i(data_addr_o), .data_wdata_i(data_wdata_o),
		.data_ack_o(data_ack_i), .data_rdata_o(data_rdata_i)
	);

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("Fail %s expected %h actual %h", name, exp_v, act_v);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// ------------------------------
	// checks
	reset_addr: assert property (@(posedge clock_bus_i) $rose(reset_i) |->
		inst_addr_o == RESET_PC)
		else report_mismatch("reset_pc", RESET_PC, inst_addr_o);
	reset_ports: assert property (@(posedge clock_bus_i) $rose(reset_i) |->
		inst_req_o && !data_req_o && !data_wren_o)
		else report_problem("wrong request levels right after reset");

	// four-phase rule on both ports
	inst_fall: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		$fell(inst_req_o) |-> $past(inst_ack_i))
		else report_problem("instruction req dropped before ack");
	inst_rise: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		$rose(inst_req_o) |-> $past(!inst_ack_i))
		else report_problem("instruction req raised while ack high");
	data_fall: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		$fell(data_req_o) |-> $past(data_ack_i))
		else report_problem("data req dropped before ack");
	data_rise: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		$rose(data_req_o) |-> $past(!data_ack_i))
		else report_problem("data req raised while ack high");

	// store stream, address and data held stable while req is up
	store_extra: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		data_req_o && data_wren_o |-> store_idx < STORE_COUNT)
		else report_problem("store beyond the end of the expected list");
	store_addr: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		data_req_o && data_wren_o && store_idx < STORE_COUNT |->
		data_addr_o == EXP_ADDR[store_idx])
		else report_mismatch("store_addr", EXP_ADDR[store_idx], data_addr_o);
	store_data: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		data_req_o && data_wren_o && store_idx < STORE_COUNT |->
		data_wdata_o == EXP_DATA[store_idx])
		else report_mismatch("store_data", EXP_DATA[store_idx], data_wdata_o);
	no_poison: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		data_req_o && data_wren_o |-> data_wdata_o != POISON)
		else report_problem("store from a skipped instruction reached memory");

	// a store counts once its req has fallen
	always @(negedge clock_bus_i) begin
		if (!reset_i) begin
			store_idx <= 0;
			store_prev <= 1'b0;
		end else begin
			store_prev <= data_req_o && data_wren_o;
			if (store_prev && !data_req_o)
				store_idx <= store_idx + 1;
		end
	end

	// ------------------------------
	// reset, then run past the last store or timeout
	initial begin
		clock_bus_i = 1'b0;
		reset_i = 1'b0;
		cycles = 0;
		drain = 0;
		inst_wait = 0;
		data_wait = 0;
		repeat (2) @(posedge clock_bus_i);
		@(negedge clock_bus_i);
		reset_i <= 1'b1;
		while (drain < DRAIN_CYCLES && cycles < RUN_LIMIT) begin
			@(posedge clock_bus_i);
			cycles++;
			// the program idles in its final loop, any further store is stray
			if (store_idx == STORE_COUNT)
				drain++;
			inst_wait = (inst_req_o && !inst_ack_i) ? inst_wait + 1 : 0;
			data_wait = (data_req_o && !data_ack_i) ? data_wait + 1 : 0;
			if (inst_wait > ACK_LIMIT)
				report_problem("instruction request never acknowledged");
			if (data_wait > ACK_LIMIT)
				report_problem("data request never acknowledged");
		end
		// checks of the last rising edge settle first
		@(negedge clock_bus_i);
		if (drain == DRAIN_CYCLES) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("timeout waiting for the final store");
			$display("Testbench failed");
			$fatal(1);
		end
	end

endmodule

// File: vlog.f
hw/hart_pkg.sv
hw/pipeline_controller.sv
hw/inst_decoder.sv
hw/operand_fetch.sv
hw/execute_unit.sv
hw/memory_writeback.sv
hw/riscv_hart.sv
test/tb_memory.sv
test/tb_riscv_hart.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
	--top-module tb_riscv_hart -Mdir obj_dir -f vlog.f

# the simulation stops with a nonzero status on failure, the log decides
./obj_dir/Vtb_riscv_hart > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
	exit 1
fi
exit 0
